//--- src/bpredPkg.sv
package bpredPkg;

    // table geometry
    localparam int HIST_WIDTH = 4;                           // local history bits per slot
    localparam int PHT_DEPTH  = 1 << HIST_WIDTH;              // one counter per history pattern
    localparam int SLOT_WIDTH = 4;                           // pc index bits for bht and btb
    localparam int SLOT_DEPTH = 1 << SLOT_WIDTH;              // entries in bht and btb
    localparam int PC_WIDTH   = 32;                          // full address
    localparam int TAG_WIDTH  = PC_WIDTH - SLOT_WIDTH - 2;   // what is left above slot and offset

    // two bit saturating counter codes
    localparam logic [1:0] STRONGLY_NOT_TAKEN = 2'b00;
    localparam logic [1:0] WEAKLY_NOT_TAKEN   = 2'b01;
    localparam logic [1:0] WEAKLY_TAKEN       = 2'b10;
    localparam logic [1:0] STRONGLY_TAKEN     = 2'b11;
    localparam logic [1:0] COUNTER_RESET      = WEAKLY_TAKEN;   // counters leave reset leaning taken

    // pc word, seen either as a plain address or split for table lookup
    typedef union packed {
        logic [PC_WIDTH-1:0] raw;                   // address as fetched
        struct packed {
            logic [TAG_WIDTH-1:0]  tag;             // bits 31..6, btb compare
            logic [SLOT_WIDTH-1:0] slot;            // bits 5..2, bht and btb index
            logic [1:0]            byteOffset;      // always zero for aligned code
        } fields;
    } pcWord_u;

endpackage

//--- src/branchHistoryTable.sv
`timescale 1ns/1ns

// local history per pc slot, untagged so aliasing pcs share a history
module branchHistoryTable import bpredPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [PC_WIDTH-1:0]   fetchPc,          // lookup address from fetch
    input  logic                  resolveValid,     // branch resolved in execute
    input  logic [PC_WIDTH-1:0]   resolvePc,        // address of resolving branch
    input  logic                  resolveTaken,     // outcome to shift in
    output logic [HIST_WIDTH-1:0] fetchHistory,     // history of fetch slot
    output logic                  fetchHistValid,   // fetch slot seen a resolve
    output logic [HIST_WIDTH-1:0] resolveHistory    // pre-update history of resolve slot
);

    pcWord_u fetchWord;                             // split view of fetch pc
    pcWord_u resolveWord;                           // split view of resolve pc

    logic [SLOT_WIDTH-1:0] fetchSlot;
    logic [SLOT_WIDTH-1:0] resolveSlot;

    logic [HIST_WIDTH-1:0] history [SLOT_DEPTH];    // shift registers, newest outcome in bit 0
    logic [SLOT_DEPTH-1:0] histValid;               // slot written at least once

    assign fetchWord.raw   = fetchPc;
    assign resolveWord.raw = resolvePc;

    assign fetchSlot   = fetchWord.fields.slot;     // index bits only
    assign resolveSlot = resolveWord.fields.slot;

    // fetch read port, sees state from before the edge
    assign fetchHistory   = history[fetchSlot];
    assign fetchHistValid = histValid[fetchSlot];

    // resolve read port feeds the pht write index
    assign resolveHistory = history[resolveSlot];   // old value, update lands on the edge

    // update on resolve
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < SLOT_DEPTH; i++) begin
                history[i] <= '0;                   // histories start clean
            end
            histValid <= '0;                        // nothing trained yet
        end else if (resolveValid) begin
            history[resolveSlot]   <= {history[resolveSlot][HIST_WIDTH-2:0], resolveTaken};
            histValid[resolveSlot] <= 1'b1;         // slot now usable for lookup
        end
    end

endmodule

//--- src/patternHistoryTable.sv
`timescale 1ns/1ns

// two bit counters indexed by local history
module patternHistoryTable import bpredPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  readEnable,   // bht slot valid
    input  logic                  fetchHit,     // btb tag match
    input  logic [HIST_WIDTH-1:0] readIndex,    // fetch history
    input  logic                  writeEnable,  // resolve strobe
    input  logic [HIST_WIDTH-1:0] writeIndex,   // history before the resolve shift
    input  logic                  taken,        // resolved outcome
    output logic                  predTaken,
    output logic                  predValid
);

    logic [1:0]           counter [PHT_DEPTH];  // saturating counters
    logic [PHT_DEPTH-1:0] cntValid;             // counter trained at least once

    logic [1:0] writeCount;                     // counter under training
    logic [1:0] nextCount;                      // its value after this resolve

    // prediction read, purely combinational
    assign predValid = readEnable && fetchHit && cntValid[readIndex];
    assign predTaken = predValid && counter[readIndex][1];  // msb set means taken side

    assign writeCount = counter[writeIndex];

    // saturating step
    always_comb begin
        nextCount = writeCount;                 // hold by default
        case (writeCount)
            STRONGLY_NOT_TAKEN: begin
                nextCount = taken ? WEAKLY_NOT_TAKEN : STRONGLY_NOT_TAKEN;  // floor
            end
            WEAKLY_NOT_TAKEN: begin
                nextCount = taken ? WEAKLY_TAKEN : STRONGLY_NOT_TAKEN;
            end
            WEAKLY_TAKEN: begin
                nextCount = taken ? STRONGLY_TAKEN : WEAKLY_NOT_TAKEN;
            end
            STRONGLY_TAKEN: begin
                nextCount = taken ? STRONGLY_TAKEN : WEAKLY_TAKEN;          // ceiling
            end
            default: begin
                nextCount = COUNTER_RESET;
            end
        endcase
    end

    // training
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                counter[i] <= COUNTER_RESET;    // weakly taken
            end
            cntValid <= '0;
        end else if (writeEnable) begin
            cntValid[writeIndex] <= 1'b1;
            if (cntValid[writeIndex]) begin
                counter[writeIndex] <= nextCount;   // first touch only validates
            end
        end
    end

endmodule

//--- src/branchTargetBuffer.sv
`timescale 1ns/1ns

// direct mapped tagged target store
module branchTargetBuffer import bpredPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [PC_WIDTH-1:0] fetchPc,        // lookup address
    input  logic                resolveValid,   // branch resolved in execute
    input  logic [PC_WIDTH-1:0] resolvePc,      // resolving branch address
    input  logic                resolveTaken,   // only taken branches allocate
    input  logic [PC_WIDTH-1:0] resolveTarget,  // computed target
    output logic                fetchHit,       // valid entry with matching tag
    output logic [PC_WIDTH-1:0] fetchTarget     // stored target of fetch slot
);

    pcWord_u fetchWord;
    pcWord_u resolveWord;

    logic [SLOT_WIDTH-1:0] fetchSlot;
    logic [SLOT_WIDTH-1:0] resolveSlot;
    logic [TAG_WIDTH-1:0]  fetchTag;
    logic [TAG_WIDTH-1:0]  resolveTag;

    logic [SLOT_DEPTH-1:0] entryValid;                  // control state, reset
    logic [TAG_WIDTH-1:0]  tagMem    [SLOT_DEPTH];      // payload
    logic [PC_WIDTH-1:0]   targetMem [SLOT_DEPTH];      // payload

    logic install;                                      // taken resolve writes the slot

    assign fetchWord.raw   = fetchPc;
    assign resolveWord.raw = resolvePc;

    assign fetchSlot   = fetchWord.fields.slot;
    assign fetchTag    = fetchWord.fields.tag;
    assign resolveSlot = resolveWord.fields.slot;
    assign resolveTag  = resolveWord.fields.tag;

    assign install = resolveValid && resolveTaken;      // not taken leaves entry alone

    // lookup, old contents until the edge
    assign fetchHit    = entryValid[fetchSlot] && (tagMem[fetchSlot] == fetchTag);
    assign fetchTarget = targetMem[fetchSlot];

    // valid bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            entryValid <= '0;                           // empty after reset
        end else if (install) begin
            entryValid[resolveSlot] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (install) begin
            tagMem[resolveSlot]    <= resolveTag;       // replaces any aliased entry
            targetMem[resolveSlot] <= resolveTarget;
        end
    end

endmodule

//--- src/branchPredictor.sv
`timescale 1ns/1ns

// local history predictor, bht feeds pht index, btb qualifies and supplies target
module branchPredictor import bpredPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [PC_WIDTH-1:0] fetchPc,        // if stage address
    input  logic                resolveValid,   // one cycle strobe from execute
    input  logic [PC_WIDTH-1:0] resolvePc,
    input  logic                resolveTaken,
    input  logic [PC_WIDTH-1:0] resolveTarget,
    output logic                predValid,      // all three tables agree
    output logic                predTaken,      // low when predValid low
    output logic [PC_WIDTH-1:0] predTarget      // meaningful only with predValid
);

    logic [HIST_WIDTH-1:0] fetchHistory;        // bht to pht read index
    logic                  fetchHistValid;      // bht slot trained
    logic [HIST_WIDTH-1:0] resolveHistory;      // bht to pht write index
    logic                  fetchHit;            // btb tag match

    branchHistoryTable historyTable (
        .clk            (clk),
        .reset          (reset),
        .fetchPc        (fetchPc),
        .resolveValid   (resolveValid),
        .resolvePc      (resolvePc),
        .resolveTaken   (resolveTaken),
        .fetchHistory   (fetchHistory),
        .fetchHistValid (fetchHistValid),
        .resolveHistory (resolveHistory)
    );

    patternHistoryTable patternTable (
        .clk         (clk),
        .reset       (reset),
        .readEnable  (fetchHistValid),
        .fetchHit    (fetchHit),
        .readIndex   (fetchHistory),
        .writeEnable (resolveValid),
        .writeIndex  (resolveHistory),          // counter the branch actually used
        .taken       (resolveTaken),
        .predTaken   (predTaken),
        .predValid   (predValid)
    );

    branchTargetBuffer targetBuffer (
        .clk           (clk),
        .reset         (reset),
        .fetchPc       (fetchPc),
        .resolveValid  (resolveValid),
        .resolvePc     (resolvePc),
        .resolveTaken  (resolveTaken),
        .resolveTarget (resolveTarget),
        .fetchHit      (fetchHit),
        .fetchTarget   (predTarget)             // straight to the output
    );

endmodule

//--- verif/branchPredictor_assertions.sv
`timescale 1ns/1ns

// protocol checks on the predictor outputs, bound into the top level
module branchPredictor_assertions (
    input logic clk,
    input logic reset,
    input logic predValid,
    input logic predTaken,
    input logic fetchHit        // btb match inside the top level
);

    // taken is qualified by valid
    takenNeedsValid: assert property (
        @(posedge clk) disable iff (reset) predTaken |-> predValid
    ) else $error("predTaken high while predValid low");

    // nothing predicted while held in reset
    quietInReset: assert property (
        @(posedge clk) reset |-> (!predValid && !predTaken)
    ) else $error("prediction outputs active during reset");

    // a valid prediction always comes with a target buffer hit
    validNeedsHit: assert property (
        @(posedge clk) disable iff (reset) predValid |-> fetchHit
    ) else $error("predValid high without a target buffer hit");

endmodule

bind branchPredictor branchPredictor_assertions assertionsInst (
    .clk       (clk),
    .reset     (reset),
    .predValid (predValid),
    .predTaken (predTaken),
    .fetchHit  (fetchHit)
);

//--- verif/predictorChecker.sv
`timescale 1ns/1ns

// flat model of history, counter and target tables, compared mid cycle
module predictorChecker import bpredPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [PC_WIDTH-1:0] fetchPc,
    input  logic                resolveValid,
    input  logic [PC_WIDTH-1:0] resolvePc,
    input  logic                resolveTaken,
    input  logic [PC_WIDTH-1:0] resolveTarget,
    input  logic                predValid,      // dut outputs under test
    input  logic                predTaken,
    input  logic [PC_WIDTH-1:0] predTarget,
    output int                  mismatchCount,
    output int                  validCount,     // valid predictions seen
    output int                  notTakenCount   // valid not taken predictions seen
);

    logic [HIST_WIDTH-1:0] modelHist [SLOT_DEPTH];      // newest outcome in bit 0
    logic [SLOT_DEPTH-1:0] modelHistValid;
    logic [1:0]            modelCnt [PHT_DEPTH];
    logic [PHT_DEPTH-1:0]  modelCntValid;
    logic [SLOT_DEPTH-1:0] modelBtbValid;
    logic [TAG_WIDTH-1:0]  modelTag [SLOT_DEPTH];
    logic [PC_WIDTH-1:0]   modelTarget [SLOT_DEPTH];

    logic [SLOT_WIDTH-1:0] fSlot;
    logic [SLOT_WIDTH-1:0] rSlot;
    logic [TAG_WIDTH-1:0]  fTag;
    logic [TAG_WIDTH-1:0]  rTag;
    logic [HIST_WIDTH-1:0] fHist;
    logic [HIST_WIDTH-1:0] rHist;                       // history before this resolve
    logic                  expValid;
    logic                  expTaken;

    // saturating step, 0 floor and 3 ceiling
    function automatic logic [1:0] trainCount(input logic [1:0] count, input logic up);
        if (up) begin
            return (count == 2'd3) ? count : count + 2'd1;
        end
        return (count == 2'd0) ? count : count - 2'd1;
    endfunction

    assign fSlot = fetchPc[5:2];                        // slot field
    assign fTag  = fetchPc[31:6];                       // tag field
    assign rSlot = resolvePc[5:2];
    assign rTag  = resolvePc[31:6];
    assign fHist = modelHist[fSlot];
    assign rHist = modelHist[rSlot];

    assign expValid = modelHistValid[fSlot] && modelBtbValid[fSlot]
                      && (modelTag[fSlot] == fTag) && modelCntValid[fHist];
    assign expTaken = expValid && modelCnt[fHist][1];

    initial begin
        mismatchCount = 0;
        validCount    = 0;
        notTakenCount = 0;
    end

    // model update on the same edge as the dut
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < SLOT_DEPTH; i++) begin
                modelHist[i]   <= '0;
                modelTag[i]    <= '0;
                modelTarget[i] <= '0;
            end
            for (int i = 0; i < PHT_DEPTH; i++) begin
                modelCnt[i] <= WEAKLY_TAKEN;            // counters start leaning taken
            end
            modelHistValid <= '0;
            modelCntValid  <= '0;
            modelBtbValid  <= '0;
        end else if (resolveValid) begin
            modelHist[rSlot]      <= {rHist[HIST_WIDTH-2:0], resolveTaken};
            modelHistValid[rSlot] <= 1'b1;
            if (modelCntValid[rHist]) begin
                modelCnt[rHist] <= trainCount(modelCnt[rHist], resolveTaken);
            end
            modelCntValid[rHist] <= 1'b1;               // first touch just validates
            if (resolveTaken) begin
                modelBtbValid[rSlot] <= 1'b1;
                modelTag[rSlot]      <= rTag;
                modelTarget[rSlot]   <= resolveTarget;
            end
        end
    end

    // mid cycle, inputs settled since 1 ns after the rising edge
    always @(negedge clk) begin
        if (predValid !== expValid) begin
            $display("MISMATCH time=%0t signal=predValid expected=%0b actual=%0b",
                     $time, expValid, predValid);
            mismatchCount++;
        end
        if (predTaken !== expTaken) begin
            $display("MISMATCH time=%0t signal=predTaken expected=%0b actual=%0b",
                     $time, expTaken, predTaken);
            mismatchCount++;
        end
        if (expValid && (predTarget !== modelTarget[fSlot])) begin
            $display("MISMATCH time=%0t signal=predTarget expected=%h actual=%h",
                     $time, modelTarget[fSlot], predTarget);
            mismatchCount++;
        end
        if (expValid && predValid === 1'b1) begin
            validCount++;
            if (!expTaken) begin
                notTakenCount++;                        // a counter got below the midpoint
            end
        end
    end

endmodule

//--- verif/branchPredictorTb.sv
`timescale 1ns/1ns

module branchPredictorTb;

    localparam int CLK_HALF     = 4;            // 8 ns period
    localparam int RESET_CYCLES = 10;
    localparam int QUIET_CYCLES = 20;           // lookups only, nothing resolves
    localparam int STIM_CYCLES  = 3000;
    localparam int DONE_TIMEOUT = RESET_CYCLES + QUIET_CYCLES + STIM_CYCLES + 500;

    logic        clk;
    logic        reset;
    logic [31:0] fetchPc;
    logic        resolveValid;
    logic [31:0] resolvePc;
    logic        resolveTaken;
    logic [31:0] resolveTarget;
    logic        predValid;
    logic        predTaken;
    logic [31:0] predTarget;

    int          mismatchCount;
    int          validCount;
    int          notTakenCount;
    int          otherErrors = 0;
    bit          stimDone    = 1'b0;
    logic [31:0] lfsr;
    logic [25:0] tagPool [2];                   // two tags fighting over each slot

    // galois step, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // one lfsr step per bit
    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsrNext(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // pc from the pool, slots 0..7, aligned
    task automatic pickPc(output logic [31:0] pc);
        logic [31:0] tagBit;
        logic [31:0] slotBits;
        takeBits(1, tagBit);
        takeBits(3, slotBits);
        pc = {tagPool[tagBit[0]], 1'b0, slotBits[2:0], 2'b00};
    endtask

    // one cycle of inputs
    task automatic driveRandom(input bit allowResolve);
        logic [31:0] pc;
        logic [31:0] bits;
        pickPc(pc);
        fetchPc = pc;
        takeBits(2, bits);
        resolveValid = allowResolve && (bits[1:0] != 2'b00);    // about 3 in 4
        pickPc(pc);
        resolvePc = pc;
        takeBits(1, bits);
        resolveTaken = bits[0];
        takeBits(32, bits);
        resolveTarget = {bits[31:2], 2'b00};
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    branchPredictor branchPredictor_inst (
        .clk           (clk),
        .reset         (reset),
        .fetchPc       (fetchPc),
        .resolveValid  (resolveValid),
        .resolvePc     (resolvePc),
        .resolveTaken  (resolveTaken),
        .resolveTarget (resolveTarget),
        .predValid     (predValid),
        .predTaken     (predTaken),
        .predTarget    (predTarget)
    );

    predictorChecker checkerInst (
        .clk           (clk),
        .reset         (reset),
        .fetchPc       (fetchPc),
        .resolveValid  (resolveValid),
        .resolvePc     (resolvePc),
        .resolveTaken  (resolveTaken),
        .resolveTarget (resolveTarget),
        .predValid     (predValid),
        .predTaken     (predTaken),
        .predTarget    (predTarget),
        .mismatchCount (mismatchCount),
        .validCount    (validCount),
        .notTakenCount (notTakenCount)
    );

    initial begin : stimulus
        lfsr          = 32'h0019_714a;
        tagPool[0]    = 26'h000_1234;
        tagPool[1]    = 26'h2ab_cdef;
        reset         = 1'b1;
        fetchPc       = '0;
        resolveValid  = 1'b0;
        resolvePc     = '0;
        resolveTaken  = 1'b0;
        resolveTarget = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            driveRandom(1'b0);                  // untrained tables, no prediction expected
            @(negedge clk);
            if (predValid !== 1'b0) begin
                $display("MISMATCH time=%0t signal=predValid expected=0 actual=%0b",
                         $time, predValid);
                otherErrors++;
            end
            if (predTaken !== 1'b0) begin
                $display("MISMATCH time=%0t signal=predTaken expected=0 actual=%0b",
                         $time, predTaken);
                otherErrors++;
            end
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < STIM_CYCLES; i++) begin
            driveRandom(1'b1);
            @(posedge clk);
            #1;
        end
        resolveValid = 1'b0;
        stimDone     = 1'b1;
    end

    initial begin : supervisor
        int waited;
        waited = 0;
        while (!stimDone && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!stimDone) begin
            $display("ERROR: stimulus did not finish within %0d cycles", DONE_TIMEOUT);
            otherErrors++;
        end
        repeat (2) @(posedge clk);              // last lookup gets compared
        if (notTakenCount == 0 || validCount == notTakenCount) begin
            $display("ERROR: random run never produced both taken and not taken predictions");
            otherErrors++;
        end
        $display("mismatches %0d, other errors %0d, valid predictions %0d, not taken %0d",
                 mismatchCount, otherErrors, validCount, notTakenCount);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/bpredPkg.sv
src/branchHistoryTable.sv
src/patternHistoryTable.sv
src/branchTargetBuffer.sv
src/branchPredictor.sv
verif/branchPredictor_assertions.sv
verif/predictorChecker.sv
verif/branchPredictorTb.sv

//--- Bender.yml
package:
  name: branch_predictor

sources:
  - files:
      - src/bpredPkg.sv
      - src/branchHistoryTable.sv
      - src/patternHistoryTable.sv
      - src/branchTargetBuffer.sv
      - src/branchPredictor.sv
  - target: test
    files:
      - verif/branchPredictor_assertions.sv
      - verif/predictorChecker.sv
      - verif/branchPredictorTb.sv
